// File: common/serial_pkg.sv
package serial_pkg;

    // operations the bit engine runs, one per go strobe
    typedef enum logic [1:0]
    {
        OP_START      = 2'd0,
        OP_STOP       = 2'd1,
        OP_WRITE_BYTE = 2'd2,
        OP_READ_BYTE  = 2'd3
    } bus_op_t;

    // upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // low bit of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // layout of a control byte: code, block bits, r/w
    localparam int CTRL_BLOCK_W = 3;

endpackage

// File: common/host_pkg.sv
package host_pkg;

    localparam int ADDR_W = 11; // 2 Kbyte array
    localparam int DATA_W = 8;

    // transaction kind latched when a request is taken
    typedef enum logic [1:0]
    {
        REQ_NONE  = 2'd0,
        REQ_WRITE = 2'd1,
        REQ_READ  = 2'd2
    } req_kind_t;

endpackage

// File: common/bit_engine_if.sv
`timescale 1ns/1ps

// byte operations from the sequencer to the bit engine, one in flight
interface bit_engine_if;

    serial_pkg::bus_op_t             op;
    logic                            go;      // one cycle strobe
    logic [host_pkg::DATA_W-1:0]     tx_byte;
    logic [host_pkg::DATA_W-1:0]     rx_byte; // valid from done until next go
    logic                            done;    // last cycle of the operation

    modport seq
    (
        output op,
        output go,
        output tx_byte,
        input  rx_byte,
        input  done
    );

    modport eng
    (
        input  op,
        input  go,
        input  tx_byte,
        output rx_byte,
        output done
    );

endinterface

// File: serial/serial_bit_engine.sv
`timescale 1ns/1ps

module serial_bit_engine #(
    parameter int SCL_DIV = 2
) (
    input  logic        CLK,
    input  logic        RESET,
    bit_engine_if.eng   bus,
    output logic        scl,
    output logic        sda_low,
    input  logic        sda_in
);

    localparam int QW = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

    logic                          busy;
    serial_pkg::bus_op_t           op_q;
    logic [QW-1:0]                 qcnt;   // cycles within a quarter
    logic [1:0]                    phase;  // quarter of the bit
    logic [2:0]                    bitcnt;
    logic [host_pkg::DATA_W-1:0]   shift_q;

    logic                          is_byte;
    logic                          last_quarter;
    logic                          last_cycle;
    logic                          scl_pat;
    logic                          sdal_pat;
    logic                          scl_hold;
    logic                          sdal_hold;

    assign is_byte      = (op_q == serial_pkg::OP_WRITE_BYTE) ||
                          (op_q == serial_pkg::OP_READ_BYTE);
    assign last_quarter = (qcnt == QW'(SCL_DIV - 1));
    assign last_cycle   = last_quarter && (phase == 2'd3) &&
                          (!is_byte || (bitcnt == 3'd7));

    // line pattern for the current quarter
    always_comb
    begin
        scl_pat  = 1'b1;
        sdal_pat = 1'b0;
        case (op_q)
            serial_pkg::OP_START:
            begin
                scl_pat  = (phase != 2'd0);
                sdal_pat = phase[1];  // falls while scl is high
            end
            serial_pkg::OP_STOP:
            begin
                scl_pat  = (phase != 2'd0);
                sdal_pat = ~phase[1]; // rises while scl is high
            end
            serial_pkg::OP_WRITE_BYTE:
            begin
                scl_pat  = phase[1];
                sdal_pat = ~shift_q[host_pkg::DATA_W-1]; // msb first
            end
            default:
            begin
                scl_pat  = phase[1];
                sdal_pat = 1'b0;      // memory drives the line
            end
        endcase
    end

    // between operations the last level is held, so no stray START or STOP
    assign scl     = busy ? scl_pat : scl_hold;
    assign sda_low = busy ? sdal_pat : sdal_hold;

    assign bus.done    = busy && last_cycle;
    assign bus.rx_byte = shift_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            op_q      <= serial_pkg::OP_START;
            qcnt      <= '0;
            phase     <= 2'd0;
            bitcnt    <= 3'd0;
            scl_hold  <= 1'b1; // idle bus
            sdal_hold <= 1'b0;
        end
        else if (busy)
        begin
            scl_hold  <= scl_pat;
            sdal_hold <= sdal_pat;
            if (last_quarter)
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd3)
                begin
                    bitcnt <= bitcnt + 3'd1;
                end
            end
            else
            begin
                qcnt <= qcnt + QW'(1);
            end
            if (last_cycle)
            begin
                busy <= 1'b0;
            end
        end
        else if (bus.go)
        begin
            busy   <= 1'b1;
            op_q   <= bus.op;
            qcnt   <= '0;
            phase  <= 2'd0;
            bitcnt <= 3'd0;
        end
    end

    // shift register, loaded on go
    always_ff @(posedge CLK)
    begin
        if (!busy && bus.go)
        begin
            shift_q <= bus.tx_byte;
        end
        else if (busy && (op_q == serial_pkg::OP_READ_BYTE) &&
                 (phase == 2'd2) && (qcnt == '0))
        begin
            shift_q <= {shift_q[host_pkg::DATA_W-2:0], sda_in}; // scl rising edge
        end
        else if (busy && (op_q == serial_pkg::OP_WRITE_BYTE) &&
                 (phase == 2'd3) && last_quarter)
        begin
            shift_q <= {shift_q[host_pkg::DATA_W-2:0], 1'b0};
        end
    end

endmodule

// File: logic/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [host_pkg::ADDR_W-1:0]   addr,
    input  logic [host_pkg::DATA_W-1:0]   wr_data,
    output logic [host_pkg::DATA_W-1:0]   rd_data,
    output logic                          ack,
    bit_engine_if.seq                     eng
);

    typedef enum logic [3:0]
    {
        IDLE,
        WR_START,
        CTRL_WR,
        ADDR_WR,
        DATA_WR,
        RD_START,
        CTRL_RD,
        DATA_RD,
        STOP,
        ACKN
    } state_t;

    state_t                        state;
    host_pkg::req_kind_t           kind;
    logic [host_pkg::ADDR_W-1:0]   addr_q;
    logic [host_pkg::DATA_W-1:0]   data_q; // write data, or read result
    logic [host_pkg::DATA_W-1:0]   ctrl_wr_byte;
    logic [host_pkg::DATA_W-1:0]   ctrl_rd_byte;

    // device code, block bits a10..a8, r/w
    assign ctrl_wr_byte = {serial_pkg::DEVICE_CODE,
                           addr_q[host_pkg::ADDR_W-1 -: serial_pkg::CTRL_BLOCK_W],
                           serial_pkg::RW_WRITE};
    assign ctrl_rd_byte = {serial_pkg::DEVICE_CODE,
                           addr_q[host_pkg::ADDR_W-1 -: serial_pkg::CTRL_BLOCK_W],
                           serial_pkg::RW_READ};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= IDLE;
            kind   <= host_pkg::REQ_NONE;
            eng.go <= 1'b0;
            eng.op <= serial_pkg::OP_START;
            ack    <= 1'b0;
        end
        else
        begin
            eng.go <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (wr || rd)
                    begin
                        kind   <= wr ? host_pkg::REQ_WRITE : host_pkg::REQ_READ; // wr wins
                        eng.go <= 1'b1;
                        eng.op <= serial_pkg::OP_START;
                        state  <= WR_START;
                    end
                end
                WR_START:
                begin
                    if (eng.done)
                    begin
                        eng.go <= 1'b1;
                        eng.op <= serial_pkg::OP_WRITE_BYTE;
                        state  <= CTRL_WR;
                    end
                end
                CTRL_WR:
                begin
                    if (eng.done)
                    begin
                        eng.go <= 1'b1;
                        eng.op <= serial_pkg::OP_WRITE_BYTE;
                        state  <= ADDR_WR;
                    end
                end
                ADDR_WR:
                begin
                    if (eng.done)
                    begin
                        eng.go <= 1'b1;
                        if (kind == host_pkg::REQ_READ)
                        begin
                            eng.op <= serial_pkg::OP_START; // repeated start
                            state  <= RD_START;
                        end
                        else
                        begin
                            eng.op <= serial_pkg::OP_WRITE_BYTE;
                            state  <= DATA_WR;
                        end
                    end
                end
                RD_START:
                begin
                    if (eng.done)
                    begin
                        eng.go <= 1'b1;
                        eng.op <= serial_pkg::OP_WRITE_BYTE;
                        state  <= CTRL_RD;
                    end
                end
                CTRL_RD:
                begin
                    if (eng.done)
                    begin
                        eng.go <= 1'b1;
                        eng.op <= serial_pkg::OP_READ_BYTE;
                        state  <= DATA_RD;
                    end
                end
                DATA_WR, DATA_RD:
                begin
                    if (eng.done)
                    begin
                        eng.go <= 1'b1;
                        eng.op <= serial_pkg::OP_STOP;
                        state  <= STOP;
                    end
                end
                STOP:
                begin
                    if (eng.done)
                    begin
                        ack   <= 1'b1;
                        state <= ACKN;
                    end
                end
                ACKN:
                begin
                    ack   <= 1'b0;
                    kind  <= host_pkg::REQ_NONE;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
        if (state == DATA_RD && eng.done)
        begin
            data_q <= eng.rx_byte; // gone after the next go
        end
        if (state == STOP && eng.done && kind == host_pkg::REQ_READ)
        begin
            rd_data <= data_q; // lands with ack
        end

        case (state)
            WR_START: eng.tx_byte <= ctrl_wr_byte;
            CTRL_WR:  eng.tx_byte <= addr_q[host_pkg::DATA_W-1:0];
            ADDR_WR:  eng.tx_byte <= data_q;
            RD_START: eng.tx_byte <= ctrl_rd_byte;
            default:  eng.tx_byte <= eng.tx_byte;
        endcase
    end

endmodule

// File: logic/eeprom_host_top.sv
`timescale 1ns/1ps

module eeprom_host_top #(
    parameter int SCL_DIV = 2 // clocks per quarter of an scl period
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [host_pkg::ADDR_W-1:0]   addr,
    input  logic [host_pkg::DATA_W-1:0]   wr_data,
    output logic [host_pkg::DATA_W-1:0]   rd_data,
    output logic                          ack,
    output logic                          scl,
    output logic                          sda_low, // open drain pull-low
    input  logic                          sda_in
);

    bit_engine_if bus_if ();

    eeprom_sequencer u_sequencer (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .eng     (bus_if.seq)
    );

    serial_bit_engine #(
        .SCL_DIV (SCL_DIV)
    ) u_bit_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .bus     (bus_if.eng),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

// File: verification/eeprom_model.sv
`timescale 1ns/1ps

// serial EEPROM, 2048 bytes, decodes the two-wire framing of the host
module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,         // resolved line
    output logic sda_low,
    output logic frame_error
);

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_SEND,
        M_WAIT_STOP
    } model_state_t;

    logic [7:0]   mem [0:2047];
    model_state_t state;
    logic         scl_q;
    logic         sda_q;
    logic [7:0]   shift_in;
    logic [2:0]   nbits;
    logic [7:0]   tx;
    logic [2:0]   block;
    logic [7:0]   addr_lo;
    logic         have_addr;

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {2'b01, a[10:8], a[10:8]};
    endfunction

    task automatic flag_bad_frame(input string why);
        $display("eeprom model at %0t ns: %s", $time, why);
        frame_error <= 1'b1;
    endtask

    // lines sampled mid cycle, away from the DUT clock edge
    always @(negedge CLK)
    begin
        logic [7:0] byte_in;
        byte_in = {shift_in[6:0], sda};
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
            begin
                mem[11'(i)] <= fill_byte(11'(i));
            end
            state       <= M_IDLE;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            sda_low     <= 1'b0;
            frame_error <= 1'b0;
            nbits       <= 3'd0;
            have_addr   <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda) // start
            begin
                if (state != M_IDLE && state != M_DATA)
                begin
                    flag_bad_frame("START arrived in the middle of a frame");
                end
                state <= M_CTRL;
                nbits <= 3'd0;
            end
            else if (scl_q && scl && !sda_q && sda) // stop
            begin
                if (state != M_WAIT_STOP)
                begin
                    flag_bad_frame("STOP arrived before the transaction was complete");
                end
                state     <= M_IDLE;
                have_addr <= 1'b0;
            end
            else if (!scl_q && scl && state != M_IDLE && state != M_WAIT_STOP)
            begin
                shift_in <= byte_in;
                nbits    <= nbits + 3'd1;
                if (nbits == 3'd7)
                begin
                    case (state)
                        M_CTRL:
                        begin
                            if (byte_in[7:4] != serial_pkg::DEVICE_CODE)
                            begin
                                flag_bad_frame("control byte does not start with the device code");
                            end
                            else if (byte_in[0] == serial_pkg::RW_WRITE)
                            begin
                                block <= byte_in[3:1];
                                state <= M_ADDR;
                            end
                            else if (!have_addr || byte_in[3:1] != block)
                            begin
                                flag_bad_frame("read control byte without a matching address");
                            end
                            else
                            begin
                                tx    <= mem[{byte_in[3:1], addr_lo}];
                                state <= M_SEND;
                            end
                        end
                        M_ADDR:
                        begin
                            addr_lo   <= byte_in;
                            have_addr <= 1'b1;
                            state     <= M_DATA;
                        end
                        M_DATA:
                        begin
                            mem[{block, addr_lo}] <= byte_in;
                            state                 <= M_WAIT_STOP;
                        end
                        default: state <= M_WAIT_STOP; // read byte fully sent
                    endcase
                end
            end
            else if (scl_q && !scl)
            begin
                if (state == M_SEND)
                begin
                    sda_low <= ~tx[7]; // msb first, scl low
                    tx      <= {tx[6:0], 1'b0};
                end
                else
                begin
                    sda_low <= 1'b0;
                end
            end
        end
    end

endmodule

// File: verification/tb_eeprom_host.sv
`timescale 1ns/1ps

module tb_eeprom_host;

    localparam int SCL_DIV      = 2;
    localparam int AW           = host_pkg::ADDR_W;
    localparam int DW           = host_pkg::DATA_W;
    localparam int MEM_BYTES    = 1 << AW;
    localparam int NUM_RANDOM   = 12;
    localparam int NUM_TXN      = 2 * NUM_RANDOM + 16 + 3 + 2 + 3;
    localparam int LIMIT_CYCLES = NUM_TXN * 8 * 32 * SCL_DIV + 1000;

    typedef struct packed
    {
        host_pkg::req_kind_t kind;
        logic                check; // rd_data known at this ack
        logic [DW-1:0]       data;
    } expect_t;

    logic          CLK;
    logic          RESET;
    logic          wr;
    logic          rd;
    logic [AW-1:0] addr;
    logic [DW-1:0] wr_data;
    logic [DW-1:0] rd_data;
    logic          ack;
    logic          scl;
    logic          sda_low;
    logic          model_low;
    logic          sda_line;
    logic          frame_error;

    logic [DW-1:0] shadow [0:MEM_BYTES-1];
    expect_t       expect_q [$];
    logic          have_read = 1'b0;
    logic [DW-1:0] last_read = '0;

    assign sda_line = ~sda_low & ~model_low; // open drain

    eeprom_host_top #(
        .SCL_DIV (SCL_DIV)
    ) DUT (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_line)
    );

    eeprom_model u_model (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl         (scl),
        .sda         (sda_line),
        .sda_low     (model_low),
        .frame_error (frame_error)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #50 CLK = ~CLK;
        end
    end

    function automatic logic [DW-1:0] initial_byte(input logic [AW-1:0] a);
        return a[7:0] ^ {2'b01, a[10:8], a[10:8]};
    endfunction

    function automatic logic [DW-1:0] expected_read(input logic [AW-1:0] a);
        return shadow[a];
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_idle_lines();
        check_value(32'(scl), 32'd1, "scl while idle");
        check_value(32'(sda_low), 32'd0, "sda_low while idle");
        check_value(32'(ack), 32'd0, "ack while idle");
    endtask

    task automatic wait_for_ack();
        do
        begin
            @(posedge CLK);
        end
        while (ack !== 1'b1);
    endtask

    // wr wins when both are set; a write leaves rd_data at the last read
    task automatic record_expectation(input logic do_wr, input logic [AW-1:0] a,
                                      input logic [DW-1:0] d);
        expect_t e;
        if (do_wr)
        begin
            shadow[a] = d;
            e.kind    = host_pkg::REQ_WRITE;
            e.check   = have_read;
            e.data    = last_read;
        end
        else
        begin
            e.kind    = host_pkg::REQ_READ;
            e.check   = 1'b1;
            e.data    = expected_read(a);
            last_read = e.data;
            have_read = 1'b1;
        end
        expect_q.push_back(e);
    endtask

    task automatic issue_request(input logic do_wr, input logic do_rd,
                                 input logic [AW-1:0] a, input logic [DW-1:0] d);
        record_expectation(do_wr, a, d);
        @(posedge CLK);
        wr      <= do_wr;
        rd      <= do_rd;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        wait_for_ack();
    endtask

    // a short write pulse while the read is on the bus gets ignored
    task automatic read_with_stray_write(input logic [AW-1:0] b, input logic [AW-1:0] a,
                                         input logic [DW-1:0] d);
        record_expectation(1'b0, b, '0);
        @(posedge CLK);
        rd   <= 1'b1;
        addr <= b;
        @(posedge CLK);
        rd <= 1'b0;
        repeat (8 * SCL_DIV) @(posedge CLK);
        wr      <= 1'b1;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        wait_for_ack();
    endtask

    always @(posedge CLK)
    begin
        expect_t e;
        if (!RESET && ack === 1'b1)
        begin
            if (expect_q.size() == 0)
            begin
                $display("ack pulse at %0t ns with no request outstanding", $time);
                $display("TB FAILED");
                $fatal(1, "extra ack");
            end
            else
            begin
                e = expect_q.pop_front();
                if (e.kind == host_pkg::REQ_READ)
                begin
                    check_value(32'(rd_data), 32'(e.data), "rd_data at read ack");
                end
                else if (e.check)
                begin
                    check_value(32'(rd_data), 32'(e.data), "rd_data held over a write");
                end
            end
        end
    end

    always @(posedge CLK)
    begin
        if (frame_error === 1'b1)
        begin
            $display("the EEPROM model saw a malformed bus frame");
            $display("TB FAILED");
            $fatal(1, "bus frame error");
        end
    end

    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge CLK);
        $display("timeout: the transactions did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial
    begin
        logic [AW-1:0] rand_addr [NUM_RANDOM];
        logic [DW-1:0] low;
        logic [AW-1:0] spot;
        void'($urandom(32'he07c_5f60));
        for (int i = 0; i < MEM_BYTES; i++)
        begin
            shadow[AW'(i)] = initial_byte(AW'(i));
        end
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        repeat (3)
        begin
            @(posedge CLK);
            check_idle_lines();
        end

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            rand_addr[i] = AW'($urandom);
            issue_request(1'b1, 1'b0, rand_addr[i], DW'($urandom));
        end
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            issue_request(1'b0, 1'b1, rand_addr[i], '0);
        end

        // same low address in all eight blocks
        low = DW'($urandom);
        for (int blk = 0; blk < 8; blk++)
        begin
            issue_request(1'b1, 1'b0, {3'(blk), low}, {3'(blk), low[4:0]} ^ 8'h5c);
        end
        for (int blk = 0; blk < 8; blk++)
        begin
            issue_request(1'b0, 1'b1, {3'(blk), low}, '0);
        end

        spot = AW'($urandom);
        issue_request(1'b1, 1'b0, spot, 8'ha7);
        read_with_stray_write(spot ^ 11'h155, spot, 8'h3c);
        issue_request(1'b0, 1'b1, spot, '0);

        spot = AW'($urandom);
        issue_request(1'b1, 1'b1, spot, 8'hc6);
        issue_request(1'b0, 1'b1, spot, '0);

        // rd_data has to survive the write in between
        issue_request(1'b0, 1'b1, rand_addr[0], '0);
        issue_request(1'b1, 1'b0, rand_addr[1], 8'he1);
        issue_request(1'b0, 1'b1, rand_addr[1], '0);

        repeat (4) @(posedge CLK);
        check_idle_lines();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: list.f
common/serial_pkg.sv
common/host_pkg.sv
common/bit_engine_if.sv
serial/serial_bit_engine.sv
logic/eeprom_sequencer.sv
logic/eeprom_host_top.sv
verification/eeprom_model.sv
verification/tb_eeprom_host.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps \
    -f list.f \
    --top-module tb_eeprom_host \
    -o tb_eeprom_host &&
./obj_dir/tb_eeprom_host ||
{
    echo "simulation did not pass"
    exit 1
}
